// ==== common/shim_settings.svh ====
// Sizing for the write order shim
// Bus widths, hash width and the number of outstanding slots per side

`ifndef SHIM_SETTINGS_SVH
`define SHIM_SETTINGS_SVH

// Request address and data word widths
`define ADDR_BITS 32
`define DATA_BITS 32

// Tag width carried by the source on every request
`define TAG_BITS 16

// Width of the folded address hash kept per outstanding request
`define HASH_BITS 9

// Outstanding reads and writes allowed at any time
`define RD_SLOTS 16
`define WR_SLOTS 8

// Index widths follow from the slot counts
// These are the low tag bits that the shim overwrites on the way out
`define RD_IDX_BITS ($clog2(`RD_SLOTS))
`define WR_IDX_BITS ($clog2(`WR_SLOTS))

`endif

// ==== common/req_pkg.sv ====
// Request-side types for the write order shim
// Address and data words, and the tag word with its two slot views

`include "shim_settings.svh"

package req_pkg;

    typedef logic [`ADDR_BITS-1:0] t_addr;
    typedef logic [`DATA_BITS-1:0] t_data;

    // Read view of a tag
    // The low bits carry the read slot index while the request is in memory
    typedef struct packed {
        logic [`TAG_BITS-`RD_IDX_BITS-1:0] keep;
        logic [`RD_IDX_BITS-1:0] idx;
    } t_tag_rd;

    // Write view of a tag
    // Fewer write slots, so fewer low bits are borrowed
    typedef struct packed {
        logic [`TAG_BITS-`WR_IDX_BITS-1:0] keep;
        logic [`WR_IDX_BITS-1:0] idx;
    } t_tag_wr;

    // One tag word, read as the source's whole tag or through a slot view
    typedef union packed {
        logic [`TAG_BITS-1:0] whole;
        t_tag_rd rd;
        t_tag_wr wr;
    } t_tag;

endpackage

// ==== common/track_pkg.sv ====
// Tracker-side types for the write order shim
// Address hash, slot index types, the side selector and the hash function

`include "shim_settings.svh"

package track_pkg;

    typedef logic [`HASH_BITS-1:0] t_hash;
    typedef logic [`RD_IDX_BITS-1:0] t_rd_idx;
    typedef logic [`WR_IDX_BITS-1:0] t_wr_idx;

    // Which side a tracker serves
    typedef enum logic { side_read, side_write } t_side;

    // Hash-wide chunks needed to cover a whole address
    localparam int N_CHUNKS = (`ADDR_BITS + `HASH_BITS - 1) / `HASH_BITS;

    // Exclusive-or fold of the address in hash-wide chunks
    // The top chunk is zero padded
    function automatic t_hash addr_hash(input req_pkg::t_addr addr);
        logic [N_CHUNKS*`HASH_BITS-1:0] padded;
        t_hash folded;
        padded = '0;
        padded[`ADDR_BITS-1:0] = addr;
        folded = '0;
        for (int c = 0; c < N_CHUNKS; c++)
            folded = folded ^ padded[c*`HASH_BITS +: `HASH_BITS];
        return folded;
    endfunction

endpackage

// ==== common/trk_if.sv ====
// Link between the order stage and one slot tracker
// The order stage allocates slots and presents hash tests
// The tracker reports free space, the next slot index and test hits

`timescale 1ns/1ns
`include "shim_settings.svh"

interface trk_if
#(
    parameter int N_TEST = 1,
    parameter int IDX_BITS = `RD_IDX_BITS
);

    // Driven by the order stage
    logic alloc_en;
    track_pkg::t_hash alloc_hash;
    logic [IDX_BITS-1:0] alloc_keep;
    track_pkg::t_hash test_hash [N_TEST];
    logic [N_TEST-1:0] test_en;

    // Driven by the tracker
    logic has_free;
    logic [IDX_BITS-1:0] alloc_idx;
    logic [N_TEST-1:0] test_hit;

    modport order (output alloc_en, alloc_hash, alloc_keep, test_hash, test_en,
                   input has_free, alloc_idx, test_hit);
    modport slot (input alloc_en, alloc_hash, alloc_keep, test_hash, test_en,
                  output has_free, alloc_idx, test_hit);

endinterface

// ==== tracker/slot_tracker.sv ====
// Slot tracker for one side of the write order shim
// Hands out free slot indexes and keeps, per busy slot, the address hash
// and the tag bits that the index displaced. Answers hash tests from the
// order stage. A response frees the slot named in its tag and leaves with
// the original tag bits put back

`timescale 1ns/1ns
`include "shim_settings.svh"

module slot_tracker
#(
    parameter track_pkg::t_side SIDE = track_pkg::side_read
)
(
    input logic clk,
    input logic reset_n,
    trk_if.slot trk,
    input logic free_valid,
    input req_pkg::t_tag free_tag,
    output req_pkg::t_tag restored_tag
);

    localparam int N_SLOTS = (SIDE == track_pkg::side_read) ? `RD_SLOTS : `WR_SLOTS;
    localparam int IDX_BITS = $clog2(N_SLOTS);

    typedef logic [IDX_BITS-1:0] t_idx;

    // ============================================================
    // Free-slot heap
    // ============================================================

    // Ring of free indexes. Slot counts are powers of two so the
    // pointers wrap on their own
    t_idx free_list [N_SLOTS];
    t_idx head;
    t_idx tail;
    logic [IDX_BITS:0] free_count;

    // Slot named by the returning response
    t_idx free_idx;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // Every slot starts out free, in index order
            for (int i = 0; i < N_SLOTS; i++)
                free_list[i] <= t_idx'(i);
            head <= '0;
            tail <= '0;
            free_count <= (IDX_BITS+1)'(N_SLOTS);
        end
        else
        begin
            if (trk.alloc_en)
                head <= head + 1'b1;
            if (free_valid)
            begin
                free_list[tail] <= free_idx;
                tail <= tail + 1'b1;
            end
            // An allocation and a free in one cycle leave the count alone
            case ({trk.alloc_en, free_valid})
                2'b10: free_count <= free_count - 1'b1;
                2'b01: free_count <= free_count + 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

    assign trk.has_free = (free_count != '0);
    assign trk.alloc_idx = free_list[head];

    // ============================================================
    // Hash filter and saved tag bits
    // ============================================================

    logic [N_SLOTS-1:0] busy;
    track_pkg::t_hash slot_hash [N_SLOTS];
    t_idx slot_keep [N_SLOTS];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            busy <= '0;
        else
        begin
            // The freed slot and the allocated slot are never the same one
            if (free_valid)
                busy[free_idx] <= 1'b0;
            if (trk.alloc_en)
                busy[trk.alloc_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (trk.alloc_en)
        begin
            slot_hash[trk.alloc_idx] <= trk.alloc_hash;
            slot_keep[trk.alloc_idx] <= trk.alloc_keep;
        end
    end

    // Each enabled test hits when any busy slot holds the same hash
    always_comb
    begin
        trk.test_hit = '0;
        for (int t = 0; t < $bits(trk.test_hit); t++)
            for (int s = 0; s < N_SLOTS; s++)
                if (trk.test_en[t] && busy[s] && (slot_hash[s] == trk.test_hash[t]))
                    trk.test_hit[t] = 1'b1;
    end

    // The side picks which tag view carries the slot index
    if (SIDE == track_pkg::side_read)
    begin : g_read
        track_pkg::t_rd_idx rsp_idx;
        assign rsp_idx = free_tag.rd.idx;
        assign free_idx = rsp_idx;
        always_comb
        begin
            restored_tag = free_tag;
            restored_tag.rd.idx = slot_keep[rsp_idx];
        end
    end
    else
    begin : g_write
        track_pkg::t_wr_idx rsp_idx;
        assign rsp_idx = free_tag.wr.idx;
        assign free_idx = rsp_idx;
        always_comb
        begin
            restored_tag = free_tag;
            restored_tag.wr.idx = slot_keep[rsp_idx];
        end
    end

endmodule

// ==== order_pipe/order_pipe.sv ====
// Issue stage of the write order shim
// Holds one request beat, tests its address hashes against both slot
// trackers and sends the beat to memory when nothing blocks it. On issue
// the low tag bits are replaced by the allocated slot index

`timescale 1ns/1ns

module order_pipe
(
    input logic clk,
    input logic reset_n,
    input logic req_rd_valid,
    input req_pkg::t_addr req_rd_addr,
    input req_pkg::t_tag req_rd_tag,
    input logic req_wr_valid,
    input req_pkg::t_addr req_wr_addr,
    input req_pkg::t_tag req_wr_tag,
    input req_pkg::t_data req_wr_data,
    output logic req_ready,
    input logic mem_alm_full,
    output logic mem_rd_valid,
    output req_pkg::t_addr mem_rd_addr,
    output req_pkg::t_tag mem_rd_tag,
    output logic mem_wr_valid,
    output req_pkg::t_addr mem_wr_addr,
    output req_pkg::t_tag mem_wr_tag,
    output req_pkg::t_data mem_wr_data,
    trk_if.order rd_trk,
    trk_if.order wr_trk
);

    // ============================================================
    // Stage storage
    // ============================================================

    logic st_rd_valid;
    logic st_wr_valid;
    req_pkg::t_addr st_rd_addr;
    req_pkg::t_tag st_rd_tag;
    track_pkg::t_hash st_rd_hash;
    req_pkg::t_addr st_wr_addr;
    req_pkg::t_tag st_wr_tag;
    req_pkg::t_data st_wr_data;
    track_pkg::t_hash st_wr_hash;

    // The request port opens the cycle after reset is released,
    // once the trackers have filled their free lists
    logic ready_en;

    logic stage_full;
    logic conflict;
    logic blocked;
    logic issue;
    logic take;

    track_pkg::t_rd_idx rd_idx;
    track_pkg::t_wr_idx wr_idx;

    assign stage_full = st_rd_valid | st_wr_valid;

    // Read waits on writes. Write waits on reads and on writes
    assign conflict = rd_trk.test_hit[0] | wr_trk.test_hit[0] | wr_trk.test_hit[1];

    // Read and write of one beat leave together, so any cause stalls both
    assign blocked = stage_full &&
                     (mem_alm_full ||
                      (st_rd_valid && !rd_trk.has_free) ||
                      (st_wr_valid && !wr_trk.has_free) ||
                      conflict);

    assign issue = stage_full && !blocked;
    assign req_ready = ready_en && (!stage_full || issue);
    assign take = req_ready && (req_rd_valid || req_wr_valid);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ready_en <= 1'b0;
            st_rd_valid <= 1'b0;
            st_wr_valid <= 1'b0;
        end
        else
        begin
            ready_en <= 1'b1;
            if (take)
            begin
                st_rd_valid <= req_rd_valid;
                st_wr_valid <= req_wr_valid;
            end
            else if (issue)
            begin
                st_rd_valid <= 1'b0;
                st_wr_valid <= 1'b0;
            end
        end
    end

    // Payload follows the valids. Hashes are folded here, as the beat is taken
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            st_rd_addr <= req_rd_addr;
            st_rd_tag <= req_rd_tag;
            st_rd_hash <= track_pkg::addr_hash(req_rd_addr);
            st_wr_addr <= req_wr_addr;
            st_wr_tag <= req_wr_tag;
            st_wr_data <= req_wr_data;
            st_wr_hash <= track_pkg::addr_hash(req_wr_addr);
        end
    end

    // ============================================================
    // Tracker tests and allocation
    // ============================================================

    // Read tracker sees only the write. Write tracker sees read then write
    assign rd_trk.test_hash[0] = st_wr_hash;
    assign rd_trk.test_en[0] = st_wr_valid;
    assign wr_trk.test_hash[0] = st_rd_hash;
    assign wr_trk.test_en[0] = st_rd_valid;
    assign wr_trk.test_hash[1] = st_wr_hash;
    assign wr_trk.test_en[1] = st_wr_valid;

    assign rd_trk.alloc_en = mem_rd_valid;
    assign rd_trk.alloc_hash = st_rd_hash;
    assign rd_trk.alloc_keep = st_rd_tag.rd.idx;
    assign wr_trk.alloc_en = mem_wr_valid;
    assign wr_trk.alloc_hash = st_wr_hash;
    assign wr_trk.alloc_keep = st_wr_tag.wr.idx;

    // ============================================================
    // Memory requests
    // ============================================================

    assign rd_idx = rd_trk.alloc_idx;
    assign wr_idx = wr_trk.alloc_idx;

    assign mem_rd_valid = issue && st_rd_valid;
    assign mem_rd_addr = st_rd_addr;
    assign mem_wr_valid = issue && st_wr_valid;
    assign mem_wr_addr = st_wr_addr;
    assign mem_wr_data = st_wr_data;

    // Slot index rides in the low tag bits while the request is out
    always_comb
    begin
        mem_rd_tag = st_rd_tag;
        mem_rd_tag.rd.idx = rd_idx;
        mem_wr_tag = st_wr_tag;
        mem_wr_tag.wr.idx = wr_idx;
    end

endmodule

// ==== logic/write_order_shim.sv ====
// Top level of the write order shim
// Keeps writes ordered behind same-address reads and writes, and reads
// behind same-address writes, toward a memory that answers out of order

`timescale 1ns/1ns
`include "shim_settings.svh"

module write_order_shim
(
    input logic clk,
    input logic reset_n,

    // Request source
    input logic req_rd_valid,
    input req_pkg::t_addr req_rd_addr,
    input req_pkg::t_tag req_rd_tag,
    input logic req_wr_valid,
    input req_pkg::t_addr req_wr_addr,
    input req_pkg::t_tag req_wr_tag,
    input req_pkg::t_data req_wr_data,
    output logic req_ready,

    // Memory requests
    input logic mem_alm_full,
    output logic mem_rd_valid,
    output req_pkg::t_addr mem_rd_addr,
    output req_pkg::t_tag mem_rd_tag,
    output logic mem_wr_valid,
    output req_pkg::t_addr mem_wr_addr,
    output req_pkg::t_tag mem_wr_tag,
    output req_pkg::t_data mem_wr_data,

    // Memory responses, in any order
    input logic mem_rd_rsp_valid,
    input req_pkg::t_tag mem_rd_rsp_tag,
    input req_pkg::t_data mem_rd_rsp_data,
    input logic mem_wr_rsp_valid,
    input req_pkg::t_tag mem_wr_rsp_tag,

    // Responses back to the source
    output logic rd_rsp_valid,
    output req_pkg::t_tag rd_rsp_tag,
    output req_pkg::t_data rd_rsp_data,
    output logic wr_rsp_valid,
    output req_pkg::t_tag wr_rsp_tag
);

    // Read tracker is tested by the write only
    trk_if #(.N_TEST(1), .IDX_BITS(`RD_IDX_BITS)) rd_trk ();
    // Write tracker is tested by the read and by the write
    trk_if #(.N_TEST(2), .IDX_BITS(`WR_IDX_BITS)) wr_trk ();

    order_pipe u_order (
        .clk, .reset_n,
        .req_rd_valid, .req_rd_addr, .req_rd_tag,
        .req_wr_valid, .req_wr_addr, .req_wr_tag, .req_wr_data,
        .req_ready, .mem_alm_full,
        .mem_rd_valid, .mem_rd_addr, .mem_rd_tag,
        .mem_wr_valid, .mem_wr_addr, .mem_wr_tag, .mem_wr_data,
        .rd_trk(rd_trk.order), .wr_trk(wr_trk.order)
    );

    // Responses free their slot and leave in the same cycle
    slot_tracker #(.SIDE(track_pkg::side_read)) u_rd_trk (
        .clk, .reset_n, .trk(rd_trk.slot),
        .free_valid(mem_rd_rsp_valid), .free_tag(mem_rd_rsp_tag),
        .restored_tag(rd_rsp_tag)
    );

    slot_tracker #(.SIDE(track_pkg::side_write)) u_wr_trk (
        .clk, .reset_n, .trk(wr_trk.slot),
        .free_valid(mem_wr_rsp_valid), .free_tag(mem_wr_rsp_tag),
        .restored_tag(wr_rsp_tag)
    );

    assign rd_rsp_valid = mem_rd_rsp_valid;
    assign rd_rsp_data = mem_rd_rsp_data;
    assign wr_rsp_valid = mem_wr_rsp_valid;

endmodule

// ==== tb/shim_order_assert.sv ====
// Bound checks on the issue stage of the write order shim
// Memory back-pressure, slot allocation and request back-pressure

`timescale 1ns/1ns

module shim_order_assert
(
    input logic clk,
    input logic reset_n,
    input logic mem_alm_full,
    input logic mem_rd_valid,
    input logic mem_wr_valid,
    input logic req_ready,
    input logic stage_full,
    input logic rd_alloc_en,
    input logic rd_has_free,
    input logic wr_alloc_en,
    input logic wr_has_free
);

    // Memory asked for a pause, so neither side may issue
    a_hold_on_full: assert property (@(posedge clk) disable iff (!reset_n)
        mem_alm_full |-> !(mem_rd_valid || mem_wr_valid))
        else $error("request issued while mem_alm_full is high");

    // A slot is only taken from a tracker that has one
    a_rd_alloc_free: assert property (@(posedge clk) disable iff (!reset_n)
        rd_alloc_en |-> rd_has_free)
        else $error("read slot allocated with no free slot");

    a_wr_alloc_free: assert property (@(posedge clk) disable iff (!reset_n)
        wr_alloc_en |-> wr_has_free)
        else $error("write slot allocated with no free slot");

    // A held beat that sends nothing this cycle must push back on the source
    a_ready_blocked: assert property (@(posedge clk) disable iff (!reset_n)
        (stage_full && !(mem_rd_valid || mem_wr_valid)) |-> !req_ready)
        else $error("req_ready high while the issue stage is blocked");

endmodule

bind order_pipe shim_order_assert u_order_assert (
    .clk, .reset_n, .mem_alm_full, .mem_rd_valid, .mem_wr_valid, .req_ready, .stage_full,
    .rd_alloc_en(rd_trk.alloc_en), .rd_has_free(rd_trk.has_free),
    .wr_alloc_en(wr_trk.alloc_en), .wr_has_free(wr_trk.has_free)
);

// ==== tb/tb_write_order.sv ====
// Testbench for the write order shim
// Sends random request beats over a small address pool, models a memory
// that answers out of order and checks issue legality, capacity,
// tag restore and completion of every request

`timescale 1ns/1ns
`include "shim_settings.svh"

module tb_write_order;

    localparam int N_BEATS = 400;
    // Generous bound on cycles, scaled by the number of beats
    localparam int LIMIT = 40 * N_BEATS;

    typedef struct packed {
        logic rd;
        logic wr;
        req_pkg::t_addr rd_addr;
        req_pkg::t_tag rd_tag;
        req_pkg::t_addr wr_addr;
        req_pkg::t_tag wr_tag;
        req_pkg::t_data wr_data;
    } t_beat;

    // One request that has gone to memory and awaits its response
    typedef struct packed {
        logic is_wr;
        req_pkg::t_addr addr;
        req_pkg::t_tag mem_tag;
        req_pkg::t_tag orig_tag;
    } t_out;

    logic clk;
    logic reset_n;
    logic req_rd_valid;
    req_pkg::t_addr req_rd_addr;
    req_pkg::t_tag req_rd_tag;
    logic req_wr_valid;
    req_pkg::t_addr req_wr_addr;
    req_pkg::t_tag req_wr_tag;
    req_pkg::t_data req_wr_data;
    logic req_ready;
    logic mem_alm_full;
    logic mem_rd_valid;
    req_pkg::t_addr mem_rd_addr;
    req_pkg::t_tag mem_rd_tag;
    logic mem_wr_valid;
    req_pkg::t_addr mem_wr_addr;
    req_pkg::t_tag mem_wr_tag;
    req_pkg::t_data mem_wr_data;
    logic mem_rd_rsp_valid;
    req_pkg::t_tag mem_rd_rsp_tag;
    req_pkg::t_data mem_rd_rsp_data;
    logic mem_wr_rsp_valid;
    req_pkg::t_tag mem_wr_rsp_tag;
    logic rd_rsp_valid;
    req_pkg::t_tag rd_rsp_tag;
    req_pkg::t_data rd_rsp_data;
    logic wr_rsp_valid;
    req_pkg::t_tag wr_rsp_tag;

    integer seed = 1955;
    int mismatches;
    int failures;
    int req_count;
    int issue_count;
    int rsp_count;
    int overlaps;
    int cycles;
    int burst_left;

    // Beats taken by the DUT, requests in flight, and the memory's own list
    t_beat beat_q[$];
    t_out out_q[$];
    t_out pend_q[$];

    write_order_shim u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================

    task automatic show_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        mismatches = mismatches + 1;
    endtask

    task automatic raise_error(input string what);
        $display("Error at %0t: %s", $time, what);
        failures = failures + 1;
    endtask

    task automatic print_summary();
        $display("Counts: req %0d issued %0d rsp %0d overlaps %0d mismatches %0d errors %0d",
                 req_count, issue_count, rsp_count, overlaps, mismatches, failures);
    endtask

    // Addresses come from a pool of sixteen words so that conflicts are frequent
    function automatic req_pkg::t_addr pool_addr();
        return 32'h0000_1000 + 32'(($unsigned($random(seed)) % 16) * 4);
    endfunction

    // Reference rule on exact addresses
    // A write needs no request to its address in flight, a read needs no write
    function automatic logic issue_legal(input logic is_wr, input req_pkg::t_addr addr);
        logic legal;
        legal = 1'b1;
        foreach (out_q[i])
            if (out_q[i].addr == addr && (is_wr || out_q[i].is_wr))
                legal = 1'b0;
        return legal;
    endfunction

    task automatic track_issue(input logic is_wr, input req_pkg::t_addr addr,
                               input req_pkg::t_addr exp_addr, input req_pkg::t_tag tag,
                               input req_pkg::t_tag exp_tag);
        int same_side;
        int same_rd;
        logic legal;
        t_out o;
        same_side = 0;
        same_rd = 0;
        foreach (out_q[i])
        begin
            if (out_q[i].is_wr == is_wr)
                same_side++;
            if (!out_q[i].is_wr && out_q[i].addr == addr)
                same_rd++;
        end
        if (addr != exp_addr)
            show_mismatch(is_wr ? "wr_addr" : "rd_addr", exp_addr, addr);
        // Only the bits above the slot index must survive the trip out
        if (!is_wr && tag.rd.keep != exp_tag.rd.keep)
            show_mismatch("rd_tag_keep", 32'(exp_tag.rd.keep), 32'(tag.rd.keep));
        if (is_wr && tag.wr.keep != exp_tag.wr.keep)
            show_mismatch("wr_tag_keep", 32'(exp_tag.wr.keep), 32'(tag.wr.keep));
        legal = issue_legal(is_wr, addr);
        if (legal != 1'b1)
            show_mismatch(is_wr ? "write_order" : "read_order", 32'd1, 32'(legal));
        if (is_wr && same_side >= `WR_SLOTS)
            raise_error($sformatf("more than %0d writes outstanding", `WR_SLOTS));
        if (!is_wr && same_side >= `RD_SLOTS)
            raise_error($sformatf("more than %0d reads outstanding", `RD_SLOTS));
        if (!is_wr && same_rd > 0)
            overlaps++;
        o.is_wr = is_wr;
        o.addr = addr;
        o.mem_tag = tag;
        o.orig_tag = exp_tag;
        out_q.push_back(o);
        pend_q.push_back(o);
        issue_count++;
    endtask

    task automatic retire_response(input logic is_wr, input req_pkg::t_tag mem_tag,
                                   input req_pkg::t_tag rsp_tag, input req_pkg::t_data rsp_data);
        int found;
        found = -1;
        foreach (out_q[i])
            if (found < 0 && out_q[i].is_wr == is_wr && out_q[i].mem_tag == mem_tag)
                found = i;
        if (found < 0)
            raise_error($sformatf("response tag %h matches no outstanding request", mem_tag));
        else
        begin
            if (rsp_tag.whole != out_q[found].orig_tag.whole)
                show_mismatch(is_wr ? "wr_tag_restore" : "rd_tag_restore",
                              32'(out_q[found].orig_tag.whole), 32'(rsp_tag.whole));
            // The memory model returns the inverted address as read data
            if (!is_wr && rsp_data != ~out_q[found].addr)
                show_mismatch("rd_data", ~out_q[found].addr, rsp_data);
            out_q.delete(found);
            rsp_count++;
        end
    endtask

    // ============================================================
    // Out-of-order memory model
    // ============================================================

    initial
    begin
        int pick;
        t_out p;
        mem_alm_full = 1'b0;
        mem_rd_rsp_valid = 1'b0;
        mem_rd_rsp_tag = '0;
        mem_rd_rsp_data = '0;
        mem_wr_rsp_valid = 1'b0;
        mem_wr_rsp_tag = '0;
        burst_left = 0;
        @(posedge reset_n);
        forever
        begin
            @(posedge clk);
            #1;
            mem_rd_rsp_valid = 1'b0;
            mem_wr_rsp_valid = 1'b0;
            // Almost-full comes in short bursts
            if (burst_left > 0)
                burst_left--;
            else if (($random(seed) & 15) == 0)
                burst_left = 1 + ($unsigned($random(seed)) % 6);
            mem_alm_full = (burst_left > 0);
            // At most one response per cycle, picked at random from what is pending
            if (pend_q.size() > 0 && ($random(seed) & 1))
            begin
                pick = $unsigned($random(seed)) % pend_q.size();
                p = pend_q[pick];
                pend_q.delete(pick);
                if (p.is_wr)
                begin
                    mem_wr_rsp_valid = 1'b1;
                    mem_wr_rsp_tag = p.mem_tag;
                end
                else
                begin
                    mem_rd_rsp_valid = 1'b1;
                    mem_rd_rsp_tag = p.mem_tag;
                    mem_rd_rsp_data = ~p.addr;
                end
            end
        end
    end

    // ============================================================
    // Comparing process sampled at the falling edge
    // ============================================================

    always @(negedge clk)
    begin
        t_beat b;
        t_beat nb;
        if (reset_n)
        begin
            if (mem_rd_valid || mem_wr_valid)
            begin
                if (mem_alm_full)
                    raise_error("request issued while mem_alm_full was high");
                if (beat_q.size() == 0)
                    raise_error("request issued with no beat waiting");
                else
                begin
                    b = beat_q.pop_front();
                    if (mem_rd_valid != b.rd)
                        show_mismatch("issue_rd", 32'(b.rd), 32'(mem_rd_valid));
                    if (mem_wr_valid != b.wr)
                        show_mismatch("issue_wr", 32'(b.wr), 32'(mem_wr_valid));
                    if (mem_rd_valid)
                        track_issue(1'b0, mem_rd_addr, b.rd_addr, mem_rd_tag, b.rd_tag);
                    if (mem_wr_valid)
                        track_issue(1'b1, mem_wr_addr, b.wr_addr, mem_wr_tag, b.wr_tag);
                    if (mem_wr_valid && mem_wr_data != b.wr_data)
                        show_mismatch("wr_data", b.wr_data, mem_wr_data);
                end
            end
            // Responses retire after the issue test since the DUT frees slots at the edge
            if (rd_rsp_valid)
                retire_response(1'b0, mem_rd_rsp_tag, rd_rsp_tag, rd_rsp_data);
            if (wr_rsp_valid)
                retire_response(1'b1, mem_wr_rsp_tag, wr_rsp_tag, '0);
            if (req_ready && (req_rd_valid || req_wr_valid))
            begin
                nb.rd = req_rd_valid;
                nb.wr = req_wr_valid;
                nb.rd_addr = req_rd_addr;
                nb.rd_tag = req_rd_tag;
                nb.wr_addr = req_wr_addr;
                nb.wr_tag = req_wr_tag;
                nb.wr_data = req_wr_data;
                beat_q.push_back(nb);
                req_count = req_count + int'(req_rd_valid) + int'(req_wr_valid);
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > LIMIT)
        begin
            raise_error($sformatf("run did not complete within %0d cycles", LIMIT));
            print_summary();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ============================================================
    // Request source
    // ============================================================

    initial
    begin
        int kind;
        reset_n = 1'b0;
        req_rd_valid = 1'b0;
        req_rd_addr = '0;
        req_rd_tag = '0;
        req_wr_valid = 1'b0;
        req_wr_addr = '0;
        req_wr_tag = '0;
        req_wr_data = '0;
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        for (int n = 0; n < N_BEATS; n++)
        begin
            // An idle cycle now and then
            if (($random(seed) & 7) == 0)
            begin
                req_rd_valid = 1'b0;
                req_wr_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            // Read only, write only, or both to different addresses
            kind = $unsigned($random(seed)) % 3;
            req_rd_valid = (kind != 1);
            req_wr_valid = (kind != 0);
            req_rd_addr = pool_addr();
            req_wr_addr = pool_addr();
            if (req_wr_addr == req_rd_addr)
                req_wr_addr = req_wr_addr ^ 32'h4;
            req_rd_tag = 16'($random(seed));
            req_wr_tag = 16'($random(seed));
            req_wr_data = 32'($random(seed));
            // Hold the beat until ready is seen before an edge
            @(negedge clk);
            while (!req_ready)
                @(negedge clk);
            @(posedge clk);
            #1;
        end
        req_rd_valid = 1'b0;
        req_wr_valid = 1'b0;
        while (beat_q.size() != 0 || issue_count != req_count || rsp_count != req_count)
            @(negedge clk);
        if (overlaps == 0)
            raise_error("no two reads to one address were ever outstanding together");
        print_summary();
        if (mismatches + failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/req_pkg.sv
common/track_pkg.sv
common/trk_if.sv
tracker/slot_tracker.sv
order_pipe/order_pipe.sv
logic/write_order_shim.sv
tb/shim_order_assert.sv
tb/tb_write_order.sv

// ==== Makefile ====
# Verilator build and run for the write order shim testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_write_order
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# A crash or assertion stop counts as a failure as well
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST RESULT: FAIL" >> $(LOG)
	cat $(LOG)
	! grep -q "TEST RESULT: FAIL" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
